// ==== source/isaPkg.sv ====
//////////////////////////////////////////////////////////////////////
// MIPS subset encodings: primary opcodes and R-type function codes,
// plus the ALU operation and branch kind enums used by the pipeline
//////////////////////////////////////////////////////////////////////

package isaPkg;

	// Primary opcodes, inst[31:26]
	localparam logic [5:0] opRType = 6'b000000;
	localparam logic [5:0] opAddi  = 6'b001000;
	localparam logic [5:0] opLw    = 6'b100011;
	localparam logic [5:0] opSw    = 6'b101011;
	localparam logic [5:0] opBeq   = 6'b000100;
	localparam logic [5:0] opBne   = 6'b000101;
	localparam logic [5:0] opBgtz  = 6'b000111;

	// Function codes under opRType, inst[5:0]
	localparam logic [5:0] fnAdd  = 6'b100000;
	localparam logic [5:0] fnAddu = 6'b100001;
	localparam logic [5:0] fnSub  = 6'b100010;
	localparam logic [5:0] fnSubu = 6'b100011;
	localparam logic [5:0] fnAnd  = 6'b100100;
	localparam logic [5:0] fnOr   = 6'b100101;
	localparam logic [5:0] fnSll  = 6'b000000;
	localparam logic [5:0] fnSlt  = 6'b101010;
	localparam logic [5:0] fnSltu = 6'b101011;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSll,
		aluSlt,
		aluSltu
	} aluOpT;

	// Branch condition carried down to execute
	typedef enum logic [1:0] {
		brNone,
		brEq,
		brNe,
		brGtz
	} branchKindT;

endpackage

// ==== source/cpuPkg.sv ====
//////////////////////////////////////////////////////////////////////
// Core sizes: datapath width, register file and data memory
// geometry, program counter reset value
//////////////////////////////////////////////////////////////////////

package cpuPkg;

	localparam int dataWidth    = 32;
	localparam int regAddrWidth = 5;
	localparam int regCount     = 2 ** regAddrWidth;

	// Data memory in words, indexed by byte address bits 7 to 2
	localparam int dmemDepth     = 64;
	localparam int dmemAddrWidth = 6;

	localparam logic [dataWidth-1:0] resetPc = '0;

endpackage

// ==== source/fetchUnit.sv ====
//////////////////////////////////////////////////////////////////////
// Fetch stage program counter: steps by one word, holds on stall,
// loads the branch target on redirect
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fetchUnit (
	input  logic                         clk,
	input  logic                         rstN,
	input  logic                         stall,
	input  logic                         redirect,
	input  logic [cpuPkg::dataWidth-1:0] branchTarget,
	output logic [cpuPkg::dataWidth-1:0] pc
);
	import cpuPkg::*;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= resetPc;
		end else if (redirect) begin
			// Taken branch overrides any stall
			pc <= branchTarget;
		end else if (!stall) begin
			pc <= pc + 4;
		end
	end

endmodule

// ==== source/instDecoder.sv ====
//////////////////////////////////////////////////////////////////////
// Instruction decoder: opcode and function fields to control levels
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module instDecoder (
	input  logic [cpuPkg::dataWidth-1:0] inst,
	output logic                         regWr,
	output logic                         regDst,
	output logic                         aluSrc,
	output logic                         extSigned,
	output logic                         memWr,
	output logic                         memToReg,
	output isaPkg::aluOpT                aluOp,
	output isaPkg::branchKindT           branchKind,
	output logic                         usesRt
);
	import isaPkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	logic [4:0] rtField;
	logic [4:0] rdField;

	assign opcode  = inst[31:26];
	assign funct   = inst[5:0];
	assign rtField = inst[20:16];
	assign rdField = inst[15:11];

	always_comb begin
		// Anything not listed falls through as a nop
		regWr      = 1'b0;
		regDst     = 1'b0;
		aluSrc     = 1'b0;
		extSigned  = 1'b0;
		memWr      = 1'b0;
		memToReg   = 1'b0;
		aluOp      = aluAdd;
		branchKind = brNone;
		usesRt     = 1'b0;
		case (opcode)
			opRType: begin
				regWr  = 1'b1;
				regDst = 1'b1;
				usesRt = 1'b1;
				case (funct)
					fnAdd, fnAddu: aluOp = aluAdd;
					fnSub, fnSubu: aluOp = aluSub;
					fnAnd: aluOp = aluAnd;
					fnOr: aluOp = aluOr;
					fnSll: aluOp = aluSll;
					fnSlt: aluOp = aluSlt;
					fnSltu: aluOp = aluSltu;
					default: begin
						regWr  = 1'b0;
						usesRt = 1'b0;
					end
				endcase
			end
			opAddi, opLw: begin
				regWr     = 1'b1;
				aluSrc    = 1'b1;
				extSigned = 1'b1;
				memToReg  = (opcode == opLw);
			end
			opSw: begin
				aluSrc    = 1'b1;
				extSigned = 1'b1;
				memWr     = 1'b1;
				usesRt    = 1'b1;
			end
			opBeq, opBne, opBgtz: begin
				// Compare as rs minus rt, offset is signed
				aluOp      = aluSub;
				extSigned  = 1'b1;
				usesRt     = (opcode != opBgtz);
				branchKind = (opcode == opBeq) ? brEq : (opcode == opBne) ? brNe : brGtz;
			end
			default: ;
		endcase
		// Register 0 is never written
		if (regDst ? (rdField == 5'd0) : (rtField == 5'd0)) begin
			regWr = 1'b0;
		end
	end

endmodule

// ==== source/regFile.sv ====
//////////////////////////////////////////////////////////////////////
// 32 x 32 register file, two read ports with write-through,
// register 0 hardwired to zero
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module regFile (
	input  logic                            clk,
	input  logic                            rstN,
	input  logic                            wrEn,
	input  logic [cpuPkg::regAddrWidth-1:0] wrAddr,
	input  logic [cpuPkg::dataWidth-1:0]    wrData,
	input  logic [cpuPkg::regAddrWidth-1:0] rdAddrA,
	input  logic [cpuPkg::regAddrWidth-1:0] rdAddrB,
	output logic [cpuPkg::dataWidth-1:0]    rdDataA,
	output logic [cpuPkg::dataWidth-1:0]    rdDataB
);
	import cpuPkg::*;

	logic [dataWidth-1:0] regs [regCount];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && wrAddr != '0) begin
			regs[wrAddr] <= wrData;
		end
	end

	// Same-cycle write is visible to decode
	assign rdDataA = (rdAddrA == '0) ? '0 :
		(wrEn && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
	assign rdDataB = (rdAddrB == '0) ? '0 :
		(wrEn && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

endmodule

// ==== source/alu.sv ====
//////////////////////////////////////////////////////////////////////
// ALU: add, sub, and, or, sll, signed and unsigned set-less-than,
// with zero and sign flags of the result
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module alu (
	input  isaPkg::aluOpT                aluOp,
	input  logic [cpuPkg::dataWidth-1:0] a,
	input  logic [cpuPkg::dataWidth-1:0] b,
	input  logic [4:0]                   shamt,
	output logic [cpuPkg::dataWidth-1:0] result,
	output logic                         zero,
	output logic                         sign
);
	import cpuPkg::*;
	import isaPkg::*;

	always_comb begin
		case (aluOp)
			aluAdd: result = a + b;
			aluSub: result = a - b;
			aluAnd: result = a & b;
			aluOr: result = a | b;
			// Shift source is rt, amount from the shamt field
			aluSll: result = b << shamt;
			aluSlt: result = {{(dataWidth-1){1'b0}}, $signed(a) < $signed(b)};
			aluSltu: result = {{(dataWidth-1){1'b0}}, a < b};
			default: result = '0;
		endcase
	end

	// Flags feed branch resolution
	assign zero = (result == '0);
	assign sign = result[dataWidth-1];

endmodule

// ==== source/dataMem.sv ====
//////////////////////////////////////////////////////////////////////
// Data memory of 64 words: combinational read, synchronous write,
// every word cleared on reset
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dataMem (
	input  logic                         clk,
	input  logic                         rstN,
	input  logic                         wrEn,
	input  logic [cpuPkg::dataWidth-1:0] addr,
	input  logic [cpuPkg::dataWidth-1:0] wrData,
	output logic [cpuPkg::dataWidth-1:0] rdData
);
	import cpuPkg::*;

	logic [dataWidth-1:0]     mem [dmemDepth];
	logic [dmemAddrWidth-1:0] wordIdx;

	// Byte address wraps at 256, low two bits dropped
	assign wordIdx = addr[dmemAddrWidth+1:2];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < dmemDepth; i++) begin
				mem[i] <= '0;
			end
		end else if (wrEn) begin
			mem[wordIdx] <= wrData;
		end
	end

	assign rdData = mem[wordIdx];

endmodule

// ==== source/hazardCtrl.sv ====
//////////////////////////////////////////////////////////////////////
// Pipeline control: read-after-write stall against execute and
// memory, branch resolution and redirect
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module hazardCtrl (
	input  logic [cpuPkg::regAddrWidth-1:0] idRs,
	input  logic [cpuPkg::regAddrWidth-1:0] idRt,
	input  logic                            idUsesRt,
	input  logic                            exRegWr,
	input  logic [cpuPkg::regAddrWidth-1:0] exRw,
	input  logic                            memRegWr,
	input  logic [cpuPkg::regAddrWidth-1:0] memRw,
	input  isaPkg::branchKindT              exBranchKind,
	input  logic                            exZero,
	input  logic                            exSign,
	output logic                            stall,
	output logic                            redirect
);
	import isaPkg::*;

	logic rsHazard;
	logic rtHazard;
	logic branchTaken;

	// Writeback needs no check, the register file passes it through
	assign rsHazard = (exRegWr && exRw == idRs) || (memRegWr && memRw == idRs);
	assign rtHazard = idUsesRt &&
		((exRegWr && exRw == idRt) || (memRegWr && memRw == idRt));

	always_comb begin
		case (exBranchKind)
			brEq: branchTaken = exZero;
			brNe: branchTaken = !exZero;
			// rs minus zero is strictly positive
			brGtz: branchTaken = !exZero && !exSign;
			default: branchTaken = 1'b0;
		endcase
	end

	assign redirect = branchTaken;

	// Instruction in decode is flushed anyway on a taken branch
	assign stall = (rsHazard || rtHazard) && !branchTaken;

endmodule

// ==== source/pipeCpu.sv ====
//////////////////////////////////////////////////////////////////////
// Five-stage MIPS subset core: pipeline latches, stage datapath,
// immediate extension, operand and writeback selects
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pipeCpu (
	input  logic                            clk,
	input  logic                            rstN,
	input  logic [cpuPkg::dataWidth-1:0]    inst,
	output logic [cpuPkg::dataWidth-1:0]    instAddr,
	output logic                            wbEn,
	output logic [cpuPkg::regAddrWidth-1:0] wbReg,
	output logic [cpuPkg::dataWidth-1:0]    wbData,
	output logic                            memWrEn,
	output logic [cpuPkg::dataWidth-1:0]    memAddr,
	output logic [cpuPkg::dataWidth-1:0]    memWrData
);
	import cpuPkg::*;
	import isaPkg::*;

	logic                 stall;
	logic                 redirect;
	logic [dataWidth-1:0] pc;
	logic [dataWidth-1:0] branchTarget;

	// IF/ID
	logic [dataWidth-1:0] ifIdInst;
	logic [dataWidth-1:0] ifIdPc;

	// Decode
	logic                    idRegWr, idRegDst, idAluSrc, idExtSigned;
	logic                    idMemWr, idMemToReg, idUsesRt;
	aluOpT                   idAluOp;
	branchKindT              idBranchKind;
	logic [regAddrWidth-1:0] idRs, idRt, idRd;
	logic [dataWidth-1:0]    idRsData, idRtData;

	// ID/EX
	logic                    idExRegWr, idExMemWr, idExRegDst, idExAluSrc;
	logic                    idExExtSigned, idExMemToReg;
	branchKindT              idExBranchKind;
	aluOpT                   idExAluOp;
	logic [dataWidth-1:0]    idExRsData, idExRtData, idExPc;
	logic [15:0]             idExImm;
	logic [regAddrWidth-1:0] idExRt, idExRd;
	logic [4:0]              idExShamt;

	// Execute
	logic [dataWidth-1:0]    exImm32, exAluB, exAluOut;
	logic [regAddrWidth-1:0] exRw;
	logic                    exZero, exSign;

	// EX/MEM and MEM/WB
	logic                    exMemRegWr, exMemMemWr, exMemMemToReg;
	logic [dataWidth-1:0]    exMemAluOut, exMemRtData, memRdData;
	logic [regAddrWidth-1:0] exMemRw;
	logic                    memWbRegWr, memWbMemToReg;
	logic [dataWidth-1:0]    memWbAluOut, memWbMemData;
	logic [regAddrWidth-1:0] memWbRw;

	fetchUnit i_fetchUnit (.clk(clk), .rstN(rstN), .stall(stall), .redirect(redirect),
		.branchTarget(branchTarget), .pc(pc));

	assign instAddr = pc;

	// Zero word is the bubble, it decodes as sll to register 0
	always_ff @(posedge clk) begin
		if (!rstN || redirect) begin
			ifIdInst <= '0;
		end else if (!stall) begin
			ifIdInst <= inst;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			ifIdPc <= pc;
		end
	end

	assign idRs = ifIdInst[25:21];
	assign idRt = ifIdInst[20:16];
	assign idRd = ifIdInst[15:11];

	instDecoder i_instDecoder (.inst(ifIdInst), .regWr(idRegWr), .regDst(idRegDst),
		.aluSrc(idAluSrc), .extSigned(idExtSigned), .memWr(idMemWr), .memToReg(idMemToReg),
		.aluOp(idAluOp), .branchKind(idBranchKind), .usesRt(idUsesRt));

	regFile i_regFile (.clk(clk), .rstN(rstN), .wrEn(memWbRegWr), .wrAddr(memWbRw),
		.wrData(wbData), .rdAddrA(idRs), .rdAddrB(idRt), .rdDataA(idRsData),
		.rdDataB(idRtData));

	hazardCtrl i_hazardCtrl (.idRs(idRs), .idRt(idRt), .idUsesRt(idUsesRt),
		.exRegWr(idExRegWr), .exRw(exRw), .memRegWr(exMemRegWr), .memRw(exMemRw),
		.exBranchKind(idExBranchKind), .exZero(exZero), .exSign(exSign),
		.stall(stall), .redirect(redirect));

	// ID/EX takes a bubble on stall or flush
	always_ff @(posedge clk) begin
		if (!rstN || redirect || stall) begin
			idExRegWr      <= 1'b0;
			idExMemWr      <= 1'b0;
			idExBranchKind <= brNone;
		end else begin
			idExRegWr      <= idRegWr;
			idExMemWr      <= idMemWr;
			idExBranchKind <= idBranchKind;
		end
	end

	always_ff @(posedge clk) begin
		idExRegDst    <= idRegDst;
		idExAluSrc    <= idAluSrc;
		idExExtSigned <= idExtSigned;
		idExMemToReg  <= idMemToReg;
		idExAluOp     <= idAluOp;
		idExRsData    <= idRsData;
		idExRtData    <= idRtData;
		idExPc        <= ifIdPc;
		idExImm       <= ifIdInst[15:0];
		idExRt        <= idRt;
		idExRd        <= idRd;
		idExShamt     <= ifIdInst[10:6];
	end

	assign exImm32 = idExExtSigned ? {{16{idExImm[15]}}, idExImm} : {16'b0, idExImm};
	assign exAluB  = idExAluSrc ? exImm32 : idExRtData;
	assign exRw    = idExRegDst ? idExRd : idExRt;

	// Target relative to the following instruction, no delay slot
	assign branchTarget = idExPc + 4 + {exImm32[dataWidth-3:0], 2'b00};

	alu i_alu (.aluOp(idExAluOp), .a(idExRsData), .b(exAluB), .shamt(idExShamt),
		.result(exAluOut), .zero(exZero), .sign(exSign));

	always_ff @(posedge clk) begin
		if (!rstN) begin
			exMemRegWr <= 1'b0;
			exMemMemWr <= 1'b0;
		end else begin
			exMemRegWr <= idExRegWr;
			exMemMemWr <= idExMemWr;
		end
	end

	always_ff @(posedge clk) begin
		exMemMemToReg <= idExMemToReg;
		exMemAluOut   <= exAluOut;
		exMemRtData   <= idExRtData;
		exMemRw       <= exRw;
	end

	dataMem i_dataMem (.clk(clk), .rstN(rstN), .wrEn(exMemMemWr), .addr(exMemAluOut),
		.wrData(exMemRtData), .rdData(memRdData));

	assign memWrEn   = exMemMemWr;
	assign memAddr   = exMemAluOut;
	assign memWrData = exMemRtData;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			memWbRegWr <= 1'b0;
		end else begin
			memWbRegWr <= exMemRegWr;
		end
	end

	always_ff @(posedge clk) begin
		memWbMemToReg <= exMemMemToReg;
		memWbAluOut   <= exMemAluOut;
		memWbMemData  <= memRdData;
		memWbRw       <= exMemRw;
	end

	// Writeback select, also the retire port
	assign wbData = memWbMemToReg ? memWbMemData : memWbAluOut;
	assign wbEn   = memWbRegWr;
	assign wbReg  = memWbRw;

endmodule

// ==== tests/cpuChecker.sv ====
//////////////////////////////////////////////////////////////////////
// Instruction-set model of the MIPS subset that compares DUT
// retirements and stores in order, the first fetch address after
// reset and the final counts
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module cpuChecker #(
	parameter int progLen = 200
) (
	input  logic                            clk,
	input  logic                            rstN,
	input  logic                            done,
	input  logic [cpuPkg::dataWidth-1:0]    prog [progLen],
	input  logic [cpuPkg::dataWidth-1:0]    instAddr,
	input  logic                            wbEn,
	input  logic [cpuPkg::regAddrWidth-1:0] wbReg,
	input  logic [cpuPkg::dataWidth-1:0]    wbData,
	input  logic                            memWrEn,
	input  logic [cpuPkg::dataWidth-1:0]    memAddr,
	input  logic [cpuPkg::dataWidth-1:0]    memWrData,
	output int                              errorCount,
	output int                              retireCount,
	output int                              storeCount
);
	import cpuPkg::*;
	import isaPkg::*;

	// Expected register writes and stores in program order
	logic [regAddrWidth-1:0] expReg [$];
	logic [dataWidth-1:0]    expVal [$];
	logic [dataWidth-1:0]    expAddr [$];
	logic [dataWidth-1:0]    expData [$];
	int                      modelRetires;
	int                      modelStores;
	logic                    modelReady;
	logic                    fetchChecked;

	task automatic runModel();
		logic [dataWidth-1:0] regs [32];
		logic [dataWidth-1:0] dmem [dmemDepth];
		logic [dataWidth-1:0] word;
		logic [dataWidth-1:0] a;
		logic [dataWidth-1:0] b;
		logic [dataWidth-1:0] imm;
		logic [dataWidth-1:0] addr;
		logic [dataWidth-1:0] val;
		logic [4:0]           dst;
		logic                 wr;
		int                   idx;
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
		end
		for (int i = 0; i < dmemDepth; i++) begin
			dmem[i] = '0;
		end
		idx = 0;
		while (idx < progLen) begin
			word = prog[idx];
			a    = regs[word[25:21]];
			b    = regs[word[20:16]];
			imm  = {{16{word[15]}}, word[15:0]};
			addr = a + imm;
			dst  = word[20:16];
			wr   = 1'b0;
			val  = '0;
			idx  = idx + 1;
			case (word[31:26])
				opRType: begin
					dst = word[15:11];
					wr  = 1'b1;
					case (word[5:0])
						fnAdd, fnAddu: val = a + b;
						fnSub, fnSubu: val = a - b;
						fnAnd: val = a & b;
						fnOr: val = a | b;
						fnSll: val = b << word[10:6];
						fnSlt: val = {31'b0, $signed(a) < $signed(b)};
						fnSltu: val = {31'b0, a < b};
						default: wr = 1'b0;
					endcase
				end
				opAddi: begin
					wr  = 1'b1;
					val = addr;
				end
				opLw: begin
					wr  = 1'b1;
					val = dmem[addr[7:2]];
				end
				opSw: begin
					dmem[addr[7:2]] = b;
					expAddr.push_back(addr);
					expData.push_back(b);
				end
				// Offset counts from the instruction after the branch
				opBeq: if (a == b) idx = idx + $signed(word[15:0]);
				opBne: if (a != b) idx = idx + $signed(word[15:0]);
				opBgtz: if ($signed(a) > 0) idx = idx + $signed(word[15:0]);
				default: ;
			endcase
			if (wr && dst != 5'd0) begin
				regs[dst] = val;
				expReg.push_back(dst);
				expVal.push_back(val);
			end
		end
		modelRetires = expReg.size();
		modelStores  = expAddr.size();
	endtask

	initial begin
		errorCount   = 0;
		retireCount  = 0;
		storeCount   = 0;
		modelReady   = 1'b0;
		fetchChecked = 1'b0;
		wait (rstN === 1'b1);
		runModel();
		modelReady = 1'b1;
	end

	task automatic checkRetire();
		logic [regAddrWidth-1:0] r;
		logic [dataWidth-1:0]    v;
		if (wbReg == '0) begin
			$display("[ERROR] %0t: retirement %0d writes register 0", $time, retireCount);
			errorCount++;
		end else if (expReg.size() == 0) begin
			$display("[ERROR] %0t: retirement %0d of r%0d has no model counterpart",
				$time, retireCount, wbReg);
			errorCount++;
		end else begin
			r = expReg.pop_front();
			v = expVal.pop_front();
			if (wbReg !== r || wbData !== v) begin
				$display("[ERROR] %0t: retirement %0d wrote r%0d = %h, model expects r%0d = %h",
					$time, retireCount, wbReg, wbData, r, v);
				errorCount++;
			end
		end
		retireCount++;
	endtask

	task automatic checkStore();
		logic [dataWidth-1:0] ad;
		logic [dataWidth-1:0] d;
		if (expAddr.size() == 0) begin
			$display("[ERROR] %0t: store %0d to %h has no model counterpart",
				$time, storeCount, memAddr);
			errorCount++;
		end else begin
			ad = expAddr.pop_front();
			d  = expData.pop_front();
			if (memAddr !== ad || memWrData !== d) begin
				$display("[ERROR] %0t: store %0d wrote %h to %h, model expects %h to %h",
					$time, storeCount, memWrData, memAddr, d, ad);
				errorCount++;
			end
		end
		storeCount++;
	endtask

	// Registered outputs are sampled mid-cycle
	always @(negedge clk) begin
		if (rstN === 1'b1 && !fetchChecked) begin
			// First cycle out of reset fetches from address 0
			if (instAddr !== 32'h0) begin
				$display("[ERROR] %0t: first fetch after reset from %h, expected 0",
					$time, instAddr);
				errorCount++;
			end
			fetchChecked = 1'b1;
		end
		if (rstN === 1'b1 && modelReady) begin
			if (wbEn) begin
				checkRetire();
			end
			if (memWrEn) begin
				checkStore();
			end
		end
	end

	always @(posedge done) begin
		if (retireCount != modelRetires) begin
			$display("[ERROR] %0t: DUT retired %0d register writes, model %0d",
				$time, retireCount, modelRetires);
			errorCount++;
		end
		if (storeCount != modelStores) begin
			$display("[ERROR] %0t: DUT made %0d stores, model %0d",
				$time, storeCount, modelStores);
			errorCount++;
		end
	end

endmodule

// ==== tests/cpuTb.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench top with clock, reset, random program and instruction
// memory, watchdog, DUT and checker instances
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module cpuTb;
	import cpuPkg::*;
	import isaPkg::*;

	localparam int progLen     = 200;
	localparam int resetCycles = 8;
	localparam int drainCycles = 12;
	localparam int maxCycles   = progLen * 4 + 50;

	logic                    clk;
	logic                    rstN;
	logic                    done;
	logic [dataWidth-1:0]    inst;
	logic [dataWidth-1:0]    instAddr;
	logic                    wbEn;
	logic [regAddrWidth-1:0] wbReg;
	logic [dataWidth-1:0]    wbData;
	logic                    memWrEn;
	logic [dataWidth-1:0]    memAddr;
	logic [dataWidth-1:0]    memWrData;
	logic [dataWidth-1:0]    prog [progLen];
	int                      errorCount;
	int                      retireCount;
	int                      storeCount;

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// Zero words past the program act as nops
	assign inst = (instAddr[31:2] < progLen) ? prog[instAddr[31:2]] : '0;

	pipeCpu i_pipeCpu (.clk(clk), .rstN(rstN), .inst(inst), .instAddr(instAddr),
		.wbEn(wbEn), .wbReg(wbReg), .wbData(wbData), .memWrEn(memWrEn),
		.memAddr(memAddr), .memWrData(memWrData));

	cpuChecker #(.progLen(progLen)) i_cpuChecker (.clk(clk), .rstN(rstN), .done(done),
		.prog(prog), .instAddr(instAddr), .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData),
		.memWrEn(memWrEn), .memAddr(memAddr), .memWrData(memWrData),
		.errorCount(errorCount), .retireCount(retireCount), .storeCount(storeCount));

	function automatic logic [31:0] encodeR(logic [5:0] fn, logic [4:0] rs, logic [4:0] rt,
		logic [4:0] rd, logic [4:0] shamt);
		return {opRType, rs, rt, rd, shamt, fn};
	endfunction

	function automatic logic [31:0] encodeI(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
		logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// Registers 1 to 7 only
	function automatic logic [4:0] pickReg();
		return 5'($urandom % 7 + 1);
	endfunction

	task automatic buildProgram();
		logic [5:0] functs [9];
		logic [5:0] fn;
		functs = '{fnAdd, fnAddu, fnSub, fnSubu, fnAnd, fnOr, fnSll, fnSlt, fnSltu};
		for (int i = 0; i < progLen; i++) begin
			case ($urandom % 10)
				0, 1, 2: begin
					fn = functs[$urandom % 9];
					if (fn == fnSll) begin
						prog[i] = encodeR(fn, 5'd0, pickReg(), pickReg(), 5'($urandom % 32));
					end else begin
						prog[i] = encodeR(fn, pickReg(), pickReg(), pickReg(), 5'd0);
					end
				end
				3, 4: prog[i] = encodeI(opAddi, pickReg(), pickReg(), 16'($urandom));
				// Base register 0 with a byte offset below 256
				5: prog[i] = encodeI(opLw, 5'd0, pickReg(), 16'($urandom % 256));
				6: prog[i] = encodeI(opSw, 5'd0, pickReg(), 16'($urandom % 256));
				// Forward branches of 1 to 4 instructions
				7: prog[i] = encodeI(opBeq, pickReg(), pickReg(), 16'($urandom % 4 + 1));
				8: prog[i] = encodeI(opBne, pickReg(), pickReg(), 16'($urandom % 4 + 1));
				default: prog[i] = encodeI(opBgtz, pickReg(), 5'd0, 16'($urandom % 4 + 1));
			endcase
		end
	endtask

	initial begin
		rstN = 1'b0;
		done = 1'b0;
		void'($urandom(32'hf7b1));
		buildProgram();
		repeat (resetCycles) @(posedge clk);
		rstN <= 1'b1;
		@(posedge clk);
		// Every program word has been fetched once pc passes the end
		while (instAddr < progLen * 4) begin
			@(posedge clk);
		end
		repeat (drainCycles) @(posedge clk);
		done <= 1'b1;
		@(posedge clk);
		$display("Checked %0d retirements and %0d stores, %0d errors",
			retireCount, storeCount, errorCount);
		if (errorCount == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	initial begin
		repeat (resetCycles + maxCycles) @(posedge clk);
		$display("Timeout: the program did not run to its end within %0d cycles", maxCycles);
		$display("Something failed");
		$finish;
	end

endmodule

// ==== pipeCpu.f ====
source/isaPkg.sv
source/cpuPkg.sv
source/fetchUnit.sv
source/instDecoder.sv
source/regFile.sv
source/alu.sv
source/dataMem.sv
source/hazardCtrl.sv
source/pipeCpu.sv
tests/cpuChecker.sv
tests/cpuTb.sv
